// ==== flist.f ====
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/hazard_unit.sv
hw/reg_file.sv
hw/csr_file.sv
hw/operand_select.sv
hw/operand_stage.sv
tests/operand_checker.sv
tests/operand_stage_tb.sv

// ==== hw/csr_file.sv ====
// --------------------------------------
// machine CSRs: mstatus, mtvec, mepc and
// mcause, written on lsu retire
// --------------------------------------
`default_nettype none

module csr_file
	import isa_pkg::*;
(
	input  logic      clock_i,
	input  logic      reset_i,
	input  csr_addr_t raddr_i,
	input  logic      we_i,
	input  csr_addr_t waddr_i,
	input  word_t     wdata_i,
	output word_t     rdata_o
);

	word_t mstatus_q;
	word_t mtvec_q;
	word_t mepc_q;
	word_t mcause_q;

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			mstatus_q <= '0;
			mtvec_q   <= '0;
			mepc_q    <= '0;
			mcause_q  <= '0;
		end else if (we_i) begin
			case (waddr_i)
				MSTATUS: mstatus_q <= wdata_i;
				MTVEC:   mtvec_q   <= wdata_i;
				MEPC:    mepc_q    <= wdata_i;
				MCAUSE:  mcause_q  <= wdata_i;
				// unimplemented address, write dropped
				default: ;
			endcase
		end
	end

	always_comb begin
		case (raddr_i)
			MSTATUS: rdata_o = mstatus_q;
			MTVEC:   rdata_o = mtvec_q;
			MEPC:    rdata_o = mepc_q;
			MCAUSE:  rdata_o = mcause_q;
			default: rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/hazard_unit.sv ====
// --------------------------------------
// RAW hazard detection, decode stall and
// bypass data for register and CSR reads
// --------------------------------------
`default_nettype none

module hazard_unit
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic    clock_i,
	input  logic    reset_i,
	input  id_req_t id_req_i,
	input  exu_wr_t exu_wr_i,
	input  lsu_wr_t lsu_wr_i,
	output logic    conflict_reg0_o,
	output logic    conflict_reg1_o,
	output logic    conflict_csr_o,
	output logic    stall_o,
	output word_t   reg_bypass_o,
	output word_t   csr_bypass_o
);

	typedef enum logic {
		ST_RUN,
		ST_WAIT_LSU
	} state_t;

	state_t   state_q;
	state_t   state_d;

	reg_idx_t src0;
	reg_idx_t src1;
	reg_idx_t exu_dst;
	reg_idx_t lsu_dst;

	logic     id_busy;
	logic     exu_busy;
	logic     lsu_busy;

	logic     exu_hit0;
	logic     exu_hit1;
	logic     lsu_hit0;
	logic     lsu_hit1;
	logic     exu_conflict;
	logic     lsu_conflict;
	logic     exu_csr_hit;
	logic     lsu_csr_hit;

	logic     lsu_valid_q;
	word_t    lsu_wdata_q;
	word_t    lsu_capt_q;

	// disabled sources and destinations collapse to x0
	assign src0    = id_req_i.ren0 ? id_req_i.rs0 : '0;
	assign src1    = id_req_i.ren1 ? id_req_i.rs1 : '0;
	assign exu_dst = exu_wr_i.wd ? exu_wr_i.wreg : '0;
	assign lsu_dst = lsu_wr_i.wd ? lsu_wr_i.wreg : '0;

	assign id_busy  = id_req_i.busy;
	assign exu_busy = exu_wr_i.busy;
	// lsu result still in flight for one cycle after retire
	assign lsu_busy = lsu_wr_i.busy | lsu_valid_q;

	assign exu_hit0 = (src0 != '0) && (src0 == exu_dst) && exu_busy && id_busy;
	assign exu_hit1 = (src1 != '0) && (src1 == exu_dst) && exu_busy && id_busy;
	assign lsu_hit0 = (src0 != '0) && (src0 == lsu_dst) && lsu_busy && id_busy;
	assign lsu_hit1 = (src1 != '0) && (src1 == lsu_dst) && lsu_busy && id_busy;

	assign exu_conflict = exu_hit0 | exu_hit1;
	assign lsu_conflict = lsu_hit0 | lsu_hit1;

	assign conflict_reg0_o = exu_hit0 | lsu_hit0;
	assign conflict_reg1_o = exu_hit1 | lsu_hit1;

	assign exu_csr_hit = id_req_i.csr_ren && id_busy && exu_busy
		&& (id_req_i.csr_raddr == exu_wr_i.csr_waddr) && csr_writes(exu_wr_i.csr_op);
	assign lsu_csr_hit = id_req_i.csr_ren && id_busy && lsu_busy
		&& (id_req_i.csr_raddr == lsu_wr_i.csr_waddr) && csr_writes(lsu_wr_i.csr_op);

	assign conflict_csr_o = exu_csr_hit | lsu_csr_hit;

	// younger csr value from execute wins
	assign csr_bypass_o = exu_csr_hit ? exu_wr_i.csr_wdata :
		lsu_csr_hit ? lsu_wr_i.csr_wdata : '0;

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			lsu_valid_q <= 1'b0;
		end else begin
			lsu_valid_q <= lsu_wr_i.valid;
		end
	end

	always_ff @(posedge clock_i) begin
		lsu_wdata_q <= lsu_wr_i.reg_wdata;
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q <= ST_RUN;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_RUN: begin
				if (lsu_conflict && !lsu_valid_q) begin
					state_d = ST_WAIT_LSU;
				end
			end
			ST_WAIT_LSU: begin
				if (lsu_valid_q) begin
					state_d = ST_RUN;
				end
			end
			default: state_d = ST_RUN;
		endcase
	end

	// execute hazards have no data path, so they stall too
	assign stall_o = (state_q == ST_RUN)
		? (exu_conflict || (lsu_conflict && !lsu_valid_q))
		: !lsu_valid_q;

	// hold the retired lsu result for the waiting reader
	always_ff @(posedge clock_i) begin
		if (lsu_valid_q && ((state_q == ST_WAIT_LSU) || lsu_conflict)) begin
			lsu_capt_q <= lsu_wdata_q;
		end
	end

	// non-load results are ready early, loads only after retire
	assign reg_bypass_o = lsu_valid_q ? lsu_wdata_q :
		(lsu_conflict && !lsu_wr_i.mem_to_reg) ? lsu_wr_i.reg_wdata :
		lsu_capt_q;

	a_no_stall_from_x0: assert property (@(posedge clock_i) disable iff (reset_i)
		$rose(stall_o) |->
			(id_req_i.ren0 && (id_req_i.rs0 != '0)) || (id_req_i.ren1 && (id_req_i.rs1 != '0)))
		else $error("stall raised without a nonzero source");

	a_wait_exit: assert property (@(posedge clock_i) disable iff (reset_i)
		(state_q == ST_WAIT_LSU) && !lsu_valid_q |=> (state_q == ST_WAIT_LSU))
		else $error("left wait_lsu without a delayed lsu valid");

endmodule

`default_nettype wire

// ==== hw/isa_pkg.sv ====
// --------------------------------------
// RV32 architectural types shared by the
// register, CSR and hazard logic
// --------------------------------------
`default_nettype none

package isa_pkg;

	typedef logic [4:0]  reg_idx_t;
	typedef logic [11:0] csr_addr_t;
	typedef logic [31:0] word_t;

	// csr side effect carried down the pipe with each instruction
	typedef enum logic [2:0] {
		CSR_NONE  = 3'd0,
		CSR_CSRRW = 3'd1,
		CSR_CSRRS = 3'd2,
		CSR_ECALL = 3'd3
	} csr_op_t;

	// machine-mode csrs implemented here
	localparam csr_addr_t MSTATUS = 12'h300;
	localparam csr_addr_t MTVEC   = 12'h305;
	localparam csr_addr_t MEPC    = 12'h341;
	localparam csr_addr_t MCAUSE  = 12'h342;

	// ecall writes mepc/mcause, so it counts as a csr write
	function automatic logic csr_writes(csr_op_t op);
		return (op == CSR_CSRRW) || (op == CSR_CSRRS) || (op == CSR_ECALL);
	endfunction

endpackage

`default_nettype wire

// ==== hw/operand_select.sv ====
// --------------------------------------
// picks file read or bypass word for
// each source of the decode operands
// --------------------------------------
`default_nettype none

module operand_select
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  word_t     rdata0_i,
	input  word_t     rdata1_i,
	input  word_t     csr_rdata_i,
	input  word_t     reg_bypass_i,
	input  word_t     csr_bypass_i,
	input  logic      conflict_reg0_i,
	input  logic      conflict_reg1_i,
	input  logic      conflict_csr_i,
	output operands_t operands_o
);

	// both register sources share the one bypass word
	assign operands_o.op0     = conflict_reg0_i ? reg_bypass_i : rdata0_i;
	assign operands_o.op1     = conflict_reg1_i ? reg_bypass_i : rdata1_i;
	assign operands_o.csr_val = conflict_csr_i ? csr_bypass_i : csr_rdata_i;

endmodule

`default_nettype wire

// ==== hw/operand_stage.sv ====
// --------------------------------------
// operand stage top: register and CSR
// files, hazard unit and bypass select
// --------------------------------------
`default_nettype none

module operand_stage
	import isa_pkg::*;
	import pipe_pkg::*;
#(
	parameter int NUM_REGS = 32
) (
	input  logic      clock_i,
	input  logic      reset_i,
	input  id_req_t   id_req_i,
	input  exu_wr_t   exu_wr_i,
	input  lsu_wr_t   lsu_wr_i,
	output operands_t operands_o,
	output logic      conflict_reg0_o,
	output logic      conflict_reg1_o,
	output logic      conflict_csr_o,
	output logic      stall_o
);

	logic  reg_we;
	logic  csr_we;
	word_t rdata0;
	word_t rdata1;
	word_t csr_rdata;
	word_t reg_bypass;
	word_t csr_bypass;

	// lsu retire is the write-back port of both files
	assign reg_we = lsu_wr_i.valid && lsu_wr_i.wd && (lsu_wr_i.wreg != '0);
	assign csr_we = lsu_wr_i.valid && csr_writes(lsu_wr_i.csr_op);

	reg_file #(
		.NUM_REGS (NUM_REGS)
	) reg_file_i (
		.clock_i  (clock_i),
		.reset_i  (reset_i),
		.rs0_i    (id_req_i.rs0),
		.rs1_i    (id_req_i.rs1),
		.we_i     (reg_we),
		.wreg_i   (lsu_wr_i.wreg),
		.wdata_i  (lsu_wr_i.reg_wdata),
		.rdata0_o (rdata0),
		.rdata1_o (rdata1)
	);

	csr_file csr_file_i (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.raddr_i (id_req_i.csr_raddr),
		.we_i    (csr_we),
		.waddr_i (lsu_wr_i.csr_waddr),
		.wdata_i (lsu_wr_i.csr_wdata),
		.rdata_o (csr_rdata)
	);

	hazard_unit hazard_unit_i (
		.clock_i         (clock_i),
		.reset_i         (reset_i),
		.id_req_i        (id_req_i),
		.exu_wr_i        (exu_wr_i),
		.lsu_wr_i        (lsu_wr_i),
		.conflict_reg0_o (conflict_reg0_o),
		.conflict_reg1_o (conflict_reg1_o),
		.conflict_csr_o  (conflict_csr_o),
		.stall_o         (stall_o),
		.reg_bypass_o    (reg_bypass),
		.csr_bypass_o    (csr_bypass)
	);

	operand_select operand_select_i (
		.rdata0_i        (rdata0),
		.rdata1_i        (rdata1),
		.csr_rdata_i     (csr_rdata),
		.reg_bypass_i    (reg_bypass),
		.csr_bypass_i    (csr_bypass),
		.conflict_reg0_i (conflict_reg0_o),
		.conflict_reg1_i (conflict_reg1_o),
		.conflict_csr_i  (conflict_csr_o),
		.operands_o      (operands_o)
	);

endmodule

`default_nettype wire

// ==== hw/pipe_pkg.sv ====
// --------------------------------------
// stage traffic into the operand stage:
// decode request, execute and lsu writes
// --------------------------------------
`default_nettype none

package pipe_pkg;

	import isa_pkg::*;

	// decode read request
	typedef struct packed {
		logic      ren0;
		reg_idx_t  rs0;
		logic      ren1;
		reg_idx_t  rs1;
		logic      csr_ren;
		csr_addr_t csr_raddr;
		// high while decode holds an instruction
		logic      busy;
	} id_req_t;

	// what the instruction in execute will write
	typedef struct packed {
		logic      wd;
		reg_idx_t  wreg;
		csr_op_t   csr_op;
		csr_addr_t csr_waddr;
		word_t     csr_wdata;
		logic      busy;
	} exu_wr_t;

	// load/store result, valid pulses on retire
	typedef struct packed {
		logic      wd;
		reg_idx_t  wreg;
		word_t     reg_wdata;
		logic      mem_to_reg;
		csr_op_t   csr_op;
		csr_addr_t csr_waddr;
		word_t     csr_wdata;
		logic      valid;
		logic      busy;
	} lsu_wr_t;

	// operands handed back to decode
	typedef struct packed {
		word_t op0;
		word_t op1;
		word_t csr_val;
	} operands_t;

endpackage

`default_nettype wire

// ==== hw/reg_file.sv ====
// --------------------------------------
// integer register file, two reads and
// one write, x0 reads as zero
// --------------------------------------
`default_nettype none

module reg_file
	import isa_pkg::*;
#(
	parameter int NUM_REGS = 32
) (
	input  logic     clock_i,
	input  logic     reset_i,
	input  reg_idx_t rs0_i,
	input  reg_idx_t rs1_i,
	input  logic     we_i,
	input  reg_idx_t wreg_i,
	input  word_t    wdata_i,
	output word_t    rdata0_o,
	output word_t    rdata1_o
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (wreg_i != '0) && (wreg_i < NUM_REGS)) begin
			regs[wreg_i] <= wdata_i;
		end
	end

	// indices past NUM_REGS (rv32e) read as zero
	assign rdata0_o = ((rs0_i != '0) && (rs0_i < NUM_REGS)) ? regs[rs0_i] : '0;
	assign rdata1_o = ((rs1_i != '0) && (rs1_i < NUM_REGS)) ? regs[rs1_i] : '0;

	a_wreg_range: assert property (@(posedge clock_i) disable iff (reset_i)
		we_i |-> (wreg_i < NUM_REGS))
		else $error("register write index %0d out of range", wreg_i);

endmodule

`default_nettype wire

// ==== tests/operand_checker.sv ====
// --------------------------------------
// operand stage checker with a shadow
// register and CSR model
// --------------------------------------
`default_nettype none

module operand_checker
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic      clock_i,
	input  logic      reset_i,
	input  id_req_t   id_req_i,
	input  exu_wr_t   exu_wr_i,
	input  lsu_wr_t   lsu_wr_i,
	input  operands_t operands_i,
	input  logic      conflict_reg0_i,
	input  logic      conflict_reg1_i,
	input  logic      conflict_csr_i,
	input  logic      stall_i,
	output int        errors_o,
	output int        checks_o
);

	timeunit 1ns;
	timeprecision 1ps;

	word_t shadow_regs [32];
	word_t shadow_csr [4];
	logic  valid_d;
	logic  in_run;
	word_t lsu_word_d;
	logic  exp_c0, exp_c1, exp_csr, exu_conf, lsu_conf, exp_stall;
	word_t exp_csr_val;

	function automatic logic op_writes(csr_op_t op);
		return op inside {CSR_CSRRW, CSR_CSRRS, CSR_ECALL};
	endfunction

	// unknown addresses map to -1
	function automatic int csr_slot(csr_addr_t a);
		case (a)
			12'h300: return 0;
			12'h305: return 1;
			12'h341: return 2;
			12'h342: return 3;
			default: return -1;
		endcase
	endfunction

	function automatic logic src_hit(logic en, reg_idx_t rs, logic wd, reg_idx_t wreg, logic busy);
		return en && (rs != 0) && wd && (rs == wreg) && busy && id_req_i.busy;
	endfunction

	always_comb begin
		exp_c0 = src_hit(id_req_i.ren0, id_req_i.rs0, exu_wr_i.wd, exu_wr_i.wreg, exu_wr_i.busy)
			|| src_hit(id_req_i.ren0, id_req_i.rs0, lsu_wr_i.wd, lsu_wr_i.wreg,
			lsu_wr_i.busy || valid_d);
		exp_c1 = src_hit(id_req_i.ren1, id_req_i.rs1, exu_wr_i.wd, exu_wr_i.wreg, exu_wr_i.busy)
			|| src_hit(id_req_i.ren1, id_req_i.rs1, lsu_wr_i.wd, lsu_wr_i.wreg,
			lsu_wr_i.busy || valid_d);
		exu_conf = src_hit(id_req_i.ren0, id_req_i.rs0, exu_wr_i.wd, exu_wr_i.wreg, exu_wr_i.busy)
			|| src_hit(id_req_i.ren1, id_req_i.rs1, exu_wr_i.wd, exu_wr_i.wreg, exu_wr_i.busy);
		lsu_conf = (lsu_wr_i.busy || valid_d) && lsu_wr_i.wd && id_req_i.busy
			&& ((id_req_i.ren0 && id_req_i.rs0 != 0 && id_req_i.rs0 == lsu_wr_i.wreg)
			|| (id_req_i.ren1 && id_req_i.rs1 != 0 && id_req_i.rs1 == lsu_wr_i.wreg));
		exp_stall = in_run ? (exu_conf || (lsu_conf && !valid_d)) : !valid_d;
		exp_csr = 1'b0;
		exp_csr_val = (csr_slot(id_req_i.csr_raddr) < 0) ? '0
			: shadow_csr[csr_slot(id_req_i.csr_raddr)];
		// execute data is younger, so it is checked last
		if (id_req_i.csr_ren && id_req_i.busy && (lsu_wr_i.busy || valid_d)
			&& id_req_i.csr_raddr == lsu_wr_i.csr_waddr && op_writes(lsu_wr_i.csr_op)) begin
			exp_csr = 1'b1;
			exp_csr_val = lsu_wr_i.csr_wdata;
		end
		if (id_req_i.csr_ren && id_req_i.busy && exu_wr_i.busy
			&& id_req_i.csr_raddr == exu_wr_i.csr_waddr && op_writes(exu_wr_i.csr_op)) begin
			exp_csr = 1'b1;
			exp_csr_val = exu_wr_i.csr_wdata;
		end
	end

	task automatic compare(string what, word_t got, word_t exp);
		checks_o++;
		if (got !== exp) begin
			errors_o++;
			$display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_reg(string what, logic conf, reg_idx_t rs, word_t got);
		if (!conf) begin
			compare(what, got, shadow_regs[rs]);
		end else if (!exp_stall && valid_d) begin
			compare({what, " bypass"}, got, lsu_word_d);
		end
	endtask

	initial begin
		errors_o = 0;
		checks_o = 0;
	end

	// sampled on the rising edge, before the files update
	always @(posedge clock_i) begin
		if (reset_i) begin
			for (int i = 0; i < 32; i++) begin
				shadow_regs[i] <= '0;
			end
			for (int i = 0; i < 4; i++) begin
				shadow_csr[i] <= '0;
			end
			valid_d <= 1'b0;
			in_run  <= 1'b1;
		end else begin
			compare("conflict_reg0", word_t'(conflict_reg0_i), word_t'(exp_c0));
			compare("conflict_reg1", word_t'(conflict_reg1_i), word_t'(exp_c1));
			compare("conflict_csr", word_t'(conflict_csr_i), word_t'(exp_csr));
			compare("stall", word_t'(stall_i), word_t'(exp_stall));
			compare("csr_val", operands_i.csr_val, exp_csr_val);
			compare_reg("op0", exp_c0, id_req_i.rs0, operands_i.op0);
			compare_reg("op1", exp_c1, id_req_i.rs1, operands_i.op1);
			if (lsu_wr_i.valid && lsu_wr_i.wd && lsu_wr_i.wreg != 0) begin
				shadow_regs[lsu_wr_i.wreg] <= lsu_wr_i.reg_wdata;
			end
			if (lsu_wr_i.valid && op_writes(lsu_wr_i.csr_op)
				&& csr_slot(lsu_wr_i.csr_waddr) >= 0) begin
				shadow_csr[csr_slot(lsu_wr_i.csr_waddr)] <= lsu_wr_i.csr_wdata;
			end
			valid_d <= lsu_wr_i.valid;
			if (in_run && lsu_conf && !valid_d) begin
				in_run <= 1'b0;
			end else if (!in_run && valid_d) begin
				in_run <= 1'b1;
			end
		end
		lsu_word_d <= lsu_wr_i.reg_wdata;
	end

endmodule

`default_nettype wire

// ==== tests/operand_stage_tb.sv ====
// --------------------------------------
// operand stage testbench, scenario table
// applied on falling clock edges
// --------------------------------------
`default_nettype none

module operand_stage_tb
	import isa_pkg::*;
	import pipe_pkg::*;
;

	timeunit 1ns;
	timeprecision 1ps;

	logic      clock;
	logic      reset;
	id_req_t   id_req;
	exu_wr_t   exu_wr;
	lsu_wr_t   lsu_wr;
	operands_t operands;
	logic      c0, c1, ccsr, stall;
	int        errors, checks;

	id_req_t   tab_id [$];
	exu_wr_t   tab_exu [$];
	lsu_wr_t   tab_lsu [$];
	int        tab_hold [$];
	int        cycle_limit;
	int        cycles;

	operand_stage #(.NUM_REGS(32)) dut_i (
		.clock_i (clock), .reset_i (reset),
		.id_req_i (id_req), .exu_wr_i (exu_wr), .lsu_wr_i (lsu_wr),
		.operands_o (operands), .conflict_reg0_o (c0), .conflict_reg1_o (c1),
		.conflict_csr_o (ccsr), .stall_o (stall)
	);

	operand_checker checker_i (
		.clock_i (clock), .reset_i (reset),
		.id_req_i (id_req), .exu_wr_i (exu_wr), .lsu_wr_i (lsu_wr),
		.operands_i (operands), .conflict_reg0_i (c0), .conflict_reg1_i (c1),
		.conflict_csr_i (ccsr), .stall_i (stall), .errors_o (errors), .checks_o (checks)
	);

	function automatic id_req_t rd(reg_idx_t rs0, reg_idx_t rs1, logic cren, csr_addr_t ca);
		return '{ren0: 1'b1, rs0: rs0, ren1: 1'b1, rs1: rs1, csr_ren: cren,
			csr_raddr: ca, busy: 1'b1};
	endfunction

	task automatic add_row(id_req_t i, exu_wr_t e, lsu_wr_t l, int hold);
		tab_id.push_back(i);
		tab_exu.push_back(e);
		tab_lsu.push_back(l);
		tab_hold.push_back(hold);
	endtask

	task automatic build_table();
		word_t w0, w1, w2, w3, w4;
		w0 = $urandom();
		w1 = $urandom();
		w2 = $urandom();
		w3 = $urandom();
		w4 = $urandom();
		add_row('0, '0, '0, 2);
		// retire x5, then read it back
		add_row('0, '0, '{1'b1, 5'd5, w0, 1'b0, CSR_NONE, MSTATUS, '0, 1'b1, 1'b0}, 1);
		add_row(rd(5'd5, 5'd0, 1'b1, MSTATUS), '0, '0, 2);
		// execute hazard, and x0 never conflicts
		add_row(rd(5'd5, 5'd3, 1'b0, MSTATUS), '{1'b1, 5'd5, CSR_NONE, MEPC, w1, 1'b1}, '0, 2);
		add_row(rd(5'd0, 5'd0, 1'b0, MSTATUS), '{1'b1, 5'd0, CSR_NONE, MEPC, w1, 1'b1}, '0, 1);
		// load into x7 with a variable wait
		add_row(rd(5'd1, 5'd7, 1'b0, MSTATUS), '0,
			'{1'b1, 5'd7, w2, 1'b1, CSR_NONE, MSTATUS, '0, 1'b0, 1'b1}, 3);
		add_row(rd(5'd1, 5'd7, 1'b0, MSTATUS), '0,
			'{1'b1, 5'd7, w2, 1'b1, CSR_NONE, MSTATUS, '0, 1'b1, 1'b0}, 1);
		add_row(rd(5'd1, 5'd7, 1'b0, MSTATUS), '0,
			'{1'b1, 5'd7, w2, 1'b1, CSR_NONE, MSTATUS, '0, 1'b0, 1'b0}, 1);
		add_row('0, '0, '0, 1);
		// both stages write mepc, execute wins
		add_row(rd(5'd0, 5'd7, 1'b1, MEPC), '{1'b0, 5'd0, CSR_CSRRW, MEPC, w1, 1'b1},
			'{1'b0, 5'd0, '0, 1'b0, CSR_CSRRS, MEPC, w3, 1'b0, 1'b1}, 2);
		// x0 and unknown csr writes are dropped
		add_row('0, '0, '{1'b1, 5'd0, w4, 1'b0, CSR_CSRRW, MTVEC, w3, 1'b1, 1'b0}, 1);
		add_row('0, '0, '{1'b0, 5'd0, '0, 1'b0, CSR_ECALL, 12'h7c0, w4, 1'b1, 1'b0}, 1);
		add_row('0, '0, '0, 2);
		add_row(rd(5'd0, 5'd7, 1'b1, MTVEC), '0, '0, 2);
		add_row(rd(5'd5, 5'd0, 1'b1, 12'h7c0), '0, '0, 2);
		// the real csrs kept their values
		add_row(rd(5'd7, 5'd5, 1'b1, MSTATUS), '0, '0, 1);
		add_row(rd(5'd7, 5'd5, 1'b1, MEPC), '0, '0, 1);
		add_row(rd(5'd7, 5'd5, 1'b1, MCAUSE), '0, '0, 1);
	endtask

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		cycles = 0;
		while (cycles <= cycle_limit) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout after %0d cycles, stimulus did not finish", cycles);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		void'($urandom(80));
		reset = 1'b1;
		id_req = '0;
		exu_wr = '0;
		lsu_wr = '0;
		build_table();
		cycle_limit = tab_hold.sum() + 20;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		foreach (tab_id[i]) begin
			id_req = tab_id[i];
			exu_wr = tab_exu[i];
			lsu_wr = tab_lsu[i];
			repeat (tab_hold[i]) @(negedge clock);
		end
		id_req = '0;
		exu_wr = '0;
		lsu_wr = '0;
		repeat (3) @(negedge clock);
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
